// File: tb.f
+incdir+src
src/copad_pkg.sv
src/copad_window_if.sv
src/cluster_window.sv
src/pair_match.sv
src/copad_top.sv
testbench/copad_asserts.sv
testbench/copad_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build copad_tb with Verilator, run it, and decide pass or fail from the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f tb.f --top-module copad_tb -Mdir "$OBJ" -o copad_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$OBJ/copad_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: testbench/copad_tb.sv
// directed and streaming tests of copad_top; assumes 2-cycle latency and config held per crossing
`include "copad_config.svh"

module copad_tb
    import copad_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N          = `COPAD_N_CLUSTERS;
    localparam int POLL_LIMIT = 100;   // polls of 10 ns per wait
    localparam int STREAM_LEN = 12;

    logic   clock;
    logic   rst;
    logic   match_neighbor_pad;
    logic   match_neighbor_roll;
    delta_t match_delta_pad;
    mask_t  a_vpf;
    mask_t  b_vpf;
    logic [N*`COPAD_ROLL_W-1:0] a_roll;
    logic [N*`COPAD_ROLL_W-1:0] b_roll;
    logic [N*`COPAD_PAD_W-1:0]  a_pad;
    logic [N*`COPAD_PAD_W-1:0]  b_pad;
    logic [N*`COPAD_CNT_W-1:0]  a_cnt;
    logic [N*`COPAD_CNT_W-1:0]  b_cnt;
    mask_t  match;
    mask_t  match_upper;
    mask_t  match_lower;
    logic   any_match;

    // per-cluster stimulus, packed into the flat ports below
    roll_t  a_rolls [N];
    roll_t  b_rolls [N];
    pad_t   a_pads  [N];
    pad_t   b_pads  [N];
    cnt_t   a_cnts  [N];
    cnt_t   b_cnts  [N];

    int unsigned edge_count  = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;
    int          test_errors = 0;
    integer      seed;
    mask_t       exp_match_q [$];
    mask_t       exp_upper_q [$];
    mask_t       exp_lower_q [$];

    initial clock = 1'b0;
    always #50 clock = ~clock;
    always @(posedge clock) edge_count <= edge_count + 1;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            a_roll[i*`COPAD_ROLL_W +: `COPAD_ROLL_W] = a_rolls[i];
            b_roll[i*`COPAD_ROLL_W +: `COPAD_ROLL_W] = b_rolls[i];
            a_pad[i*`COPAD_PAD_W +: `COPAD_PAD_W]    = a_pads[i];
            b_pad[i*`COPAD_PAD_W +: `COPAD_PAD_W]    = b_pads[i];
            a_cnt[i*`COPAD_CNT_W +: `COPAD_CNT_W]    = a_cnts[i];
            b_cnt[i*`COPAD_CNT_W +: `COPAD_CNT_W]    = b_cnts[i];
        end
    end

    copad_top i_copad_top (
        .clock               (clock),
        .rst                 (rst),
        .match_neighbor_pad  (match_neighbor_pad),
        .match_neighbor_roll (match_neighbor_roll),
        .match_delta_pad     (match_delta_pad),
        .a_vpf               (a_vpf),
        .b_vpf               (b_vpf),
        .a_roll              (a_roll),
        .b_roll              (b_roll),
        .a_pad               (a_pad),
        .b_pad               (b_pad),
        .a_cnt               (a_cnt),
        .b_cnt               (b_cnt),
        .match               (match),
        .match_upper         (match_upper),
        .match_lower         (match_lower),
        .any_match           (any_match)
    );

    // --------------------
    // polls land 5 ns after a rising edge, never on a clock toggle
    task automatic wait_edges(input int n);
        int unsigned target;
        int polls;
        target = edge_count + n;
        polls  = 0;
        while (edge_count < target) begin
            #10;
            polls++;
            if (polls > POLL_LIMIT) begin
                $display("timeout: no rising clock edge within %0d ns", POLL_LIMIT * 10);
                $display("SOME TESTS FAILED");
                $finish;
            end
        end
    endtask

    task automatic clear_clusters();
        a_vpf = '0;
        b_vpf = '0;
        for (int i = 0; i < N; i++) begin
            a_rolls[i] = '0;
            b_rolls[i] = '0;
            a_pads[i]  = '0;
            b_pads[i]  = '0;
            a_cnts[i]  = '0;
            b_cnts[i]  = '0;
        end
    endtask

    task automatic set_a(input int i, input roll_t roll, input pad_t pad, input cnt_t cnt);
        a_vpf[i]   = 1'b1;
        a_rolls[i] = roll;
        a_pads[i]  = pad;
        a_cnts[i]  = cnt;
    endtask

    task automatic set_b(input int i, input roll_t roll, input pad_t pad, input cnt_t cnt);
        b_vpf[i]   = 1'b1;
        b_rolls[i] = roll;
        b_pads[i]  = pad;
        b_cnts[i]  = cnt;
    endtask

    task automatic random_crossing();
        logic [31:0] r;
        for (int i = 0; i < N; i++) begin
            r = $random(seed);
            a_rolls[i] = roll_t'(r[1:0]) + roll_t'(3);   // rolls 3..6
            a_pads[i]  = pad_t'(r[6:2]) + pad_t'(160);    // near the top edge
            a_cnts[i]  = r[9:7];
            a_vpf[i]   = r[10];
            b_rolls[i] = roll_t'(r[12:11]) + roll_t'(3);
            b_pads[i]  = pad_t'(r[17:13]) + pad_t'(160);
            b_cnts[i]  = r[20:18];
            b_vpf[i]   = r[21];
        end
    endtask

    // --------------------
    // reference model, straight from the window and roll rules
    task automatic model_crossing(output mask_t m, output mask_t mu, output mask_t ml);
        int   d;
        int   lo;
        int   hi;
        int   b_end;
        logic hit;
        mask_t mc;
        mc = '0;
        mu = '0;
        ml = '0;
        d  = match_neighbor_pad ? int'(match_delta_pad) : 0;
        for (int i = 0; i < N; i++) begin
            lo = (int'(a_pads[i]) - d < 0) ? 0 : int'(a_pads[i]) - d;
            hi = int'(a_pads[i]) + int'(a_cnts[i]) + d;
            if (hi > `COPAD_MAX_PAD) hi = `COPAD_MAX_PAD;
            for (int j = 0; j < N; j++) begin
                b_end = int'(b_pads[j]) + int'(b_cnts[j]);
                hit = a_vpf[i] && b_vpf[j]
                    && ((int'(b_pads[j]) >= lo && int'(b_pads[j]) <= hi)
                        || (b_end >= lo && b_end <= hi));
                if (hit && int'(a_rolls[i]) == int'(b_rolls[j])) mc[i] = 1'b1;
                if (hit && int'(a_rolls[i]) == int'(b_rolls[j]) + 1) mu[i] = 1'b1;
                if (hit && int'(b_rolls[j]) == int'(a_rolls[i]) + 1) ml[i] = 1'b1;
            end
        end
        m = match_neighbor_roll ? (mc | mu | ml) : mc;
    endtask

    // --------------------
    task automatic check_mask(input string test, input string what,
                              input mask_t exp, input mask_t act);
        if (act !== exp) begin
            $display("Fail %s %s: expected %b, actual %b", test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string test, input string what,
                              input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s %s: expected %b, actual %b", test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic compare_outputs(input string test, input mask_t em,
                                   input mask_t eu, input mask_t el);
        check_mask(test, "match", em, match);
        check_mask(test, "match_upper", eu, match_upper);
        check_mask(test, "match_lower", el, match_lower);
        check_flag(test, "any_match", |em, any_match);
    endtask

    // crossing was driven at this slot, result is out two edges later
    task automatic expect_after_latency(input string test, input mask_t em,
                                        input mask_t eu, input mask_t el);
        wait_edges(2);
        compare_outputs(test, em, eu, el);
    endtask

    task automatic report_test(input string test);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: ok", test);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", test, test_errors);
        end
        test_errors = 0;
    endtask

    // --------------------
    task automatic exact_pads();
        wait_edges(1);
        clear_clusters();
        match_neighbor_pad  = 1'b0;
        match_neighbor_roll = 1'b0;
        match_delta_pad     = '0;
        set_a(0, 2, 40, 3);                 // pads 40..43
        set_b(0, 2, 42, 1);
        expect_after_latency("exact_pads", 8'h01, '0, '0);
        wait_edges(1);
        set_b(0, 2, 44, 0);                 // one pad past the A end
        expect_after_latency("exact_pads", '0, '0, '0);
        report_test("exact_pads");
    endtask

    task automatic pad_tolerance();
        wait_edges(1);
        clear_clusters();
        match_neighbor_pad = 1'b1;
        match_delta_pad    = 4'd3;
        set_a(0, 1, 100, 2);                // ends at 102
        set_b(0, 1, 105, 0);
        expect_after_latency("pad_tolerance", 8'h01, '0, '0);
        wait_edges(1);
        set_b(0, 1, 106, 0);
        expect_after_latency("pad_tolerance", '0, '0, '0);
        wait_edges(1);
        match_neighbor_pad = 1'b0;          // delta ignored now
        set_b(0, 1, 105, 0);
        expect_after_latency("pad_tolerance", '0, '0, '0);
        report_test("pad_tolerance");
    endtask

    task automatic edge_clamp();
        wait_edges(1);
        clear_clusters();
        match_neighbor_pad = 1'b1;
        match_delta_pad    = 4'd5;
        set_a(0, 0, 1, 0);
        set_b(0, 0, 0, 0);
        expect_after_latency("edge_clamp", 8'h01, '0, '0);
        wait_edges(1);
        clear_clusters();
        match_delta_pad = 4'd4;
        set_a(0, 5, 188, 2);
        set_b(0, 5, 191, 0);
        expect_after_latency("edge_clamp", 8'h01, '0, '0);
        report_test("edge_clamp");
    endtask

    task automatic neighbor_rolls();
        wait_edges(1);
        clear_clusters();
        match_neighbor_pad  = 1'b0;
        match_neighbor_roll = 1'b0;
        set_a(5, 3, 60, 1);
        set_b(2, 2, 61, 0);
        expect_after_latency("neighbor_rolls", '0, 8'h20, '0);
        wait_edges(1);
        match_neighbor_roll = 1'b1;
        expect_after_latency("neighbor_rolls", 8'h20, 8'h20, '0);
        wait_edges(1);
        set_b(2, 4, 61, 0);
        expect_after_latency("neighbor_rolls", 8'h20, '0, 8'h20);
        wait_edges(1);
        clear_clusters();
        set_a(5, `COPAD_LAST_ROLL, 60, 0);  // roll 7 has no roll above
        set_b(2, 0, 60, 0);
        expect_after_latency("neighbor_rolls", '0, '0, '0);
        report_test("neighbor_rolls");
    endtask

    task automatic stream_and_reset();
        mask_t em;
        mask_t eu;
        mask_t el;
        wait_edges(1);
        match_neighbor_pad  = 1'b1;
        match_delta_pad     = 4'd2;
        match_neighbor_roll = 1'b1;
        for (int k = 0; k < STREAM_LEN + 2; k++) begin
            if (k >= 2) begin
                em = exp_match_q.pop_front();
                eu = exp_upper_q.pop_front();
                el = exp_lower_q.pop_front();
                compare_outputs("stream_and_reset", em, eu, el);
            end
            if (k < STREAM_LEN) begin
                random_crossing();
                model_crossing(em, eu, el);
                exp_match_q.push_back(em);
                exp_upper_q.push_back(eu);
                exp_lower_q.push_back(el);
            end else begin
                clear_clusters();
            end
            wait_edges(1);
        end
        clear_clusters();
        set_a(0, 4, 80, 2);
        set_b(0, 4, 81, 0);
        wait_edges(1);
        rst = 1'b1;                         // hits while the crossing is in stage 1
        wait_edges(1);
        compare_outputs("stream_and_reset", '0, '0, '0);
        rst = 1'b0;
        clear_clusters();
        report_test("stream_and_reset");
    endtask

    // --------------------
    initial begin
        seed                = 32'hcf55;
        rst                 = 1'b1;
        match_neighbor_pad  = 1'b0;
        match_neighbor_roll = 1'b0;
        match_delta_pad     = '0;
        clear_clusters();
        #5;
        wait_edges(4);
        rst = 1'b0;
        exact_pads();
        pad_tolerance();
        edge_clamp();
        neighbor_rolls();
        stream_and_reset();
        if (i_copad_top.i_copad_asserts.assert_failures != 0) begin
            $display("concurrent assertions failed %0d times",
                     i_copad_top.i_copad_asserts.assert_failures);
            fail_count++;
        end
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/copad_asserts.sv
// output checks for copad_top; reaches the stage-2 center mask through the bind port list
module copad_asserts
    import copad_pkg::*;
(
    input logic  clock,
    input logic  rst,
    input mask_t match,
    input mask_t match_upper,
    input mask_t match_lower,
    input logic  any_match,
    input mask_t match_center
);

    timeunit 1ns;
    timeprecision 1ps;

    int assert_failures = 0;   // failed checks so far

    // --------------------
    a_any_is_or: assert property (@(posedge clock) disable iff (rst) any_match == |match)
        else begin
            $error("any_match differs from the OR of match");
            assert_failures++;
        end

    // outputs are cleared one edge after rst
    a_reset_clear: assert property (@(posedge clock) rst |=>
        (match == '0 && match_upper == '0 && match_lower == '0 && !any_match))
        else begin
            $error("outputs not cleared after reset");
            assert_failures++;
        end

    // match registers the center mask of the previous cycle
    a_match_covered: assert property (@(posedge clock) disable iff (rst)
        (match & ~($past(match_center) | match_upper | match_lower)) == '0)
        else begin
            $error("match bit set without a center, upper or lower hit");
            assert_failures++;
        end

endmodule

bind copad_top copad_asserts i_copad_asserts (
    .clock        (clock),
    .rst          (rst),
    .match        (match),
    .match_upper  (match_upper),
    .match_lower  (match_lower),
    .any_match    (any_match),
    .match_center (i_pair_match.match_center)
);

// File: src/copad_top.sv
// two-cycle latency, one crossing per clock; config must stay steady while a crossing is in flight
`include "copad_config.svh"

module copad_top
    import copad_pkg::*;
(
    input  logic   clock,
    input  logic   rst,
    input  logic   match_neighbor_pad,
    input  logic   match_neighbor_roll,
    input  delta_t match_delta_pad,
    input  mask_t  a_vpf,
    input  mask_t  b_vpf,
    input  logic [`COPAD_N_CLUSTERS*`COPAD_ROLL_W-1:0] a_roll,
    input  logic [`COPAD_N_CLUSTERS*`COPAD_ROLL_W-1:0] b_roll,
    input  logic [`COPAD_N_CLUSTERS*`COPAD_PAD_W-1:0]  a_pad,
    input  logic [`COPAD_N_CLUSTERS*`COPAD_PAD_W-1:0]  b_pad,
    input  logic [`COPAD_N_CLUSTERS*`COPAD_CNT_W-1:0]  a_cnt,
    input  logic [`COPAD_N_CLUSTERS*`COPAD_CNT_W-1:0]  b_cnt,
    output mask_t  match,
    output mask_t  match_upper,
    output mask_t  match_lower,
    output logic   any_match
);

    roll_t a_roll_arr [`COPAD_N_CLUSTERS];
    roll_t b_roll_arr [`COPAD_N_CLUSTERS];
    pad_t  a_pad_arr  [`COPAD_N_CLUSTERS];
    pad_t  b_pad_arr  [`COPAD_N_CLUSTERS];
    cnt_t  a_cnt_arr  [`COPAD_N_CLUSTERS];
    cnt_t  b_cnt_arr  [`COPAD_N_CLUSTERS];

    // --------------------
    // cluster i sits in slice i of each flat vector
    for (genvar i = 0; i < `COPAD_N_CLUSTERS; i++) begin : g_unpack
        assign a_roll_arr[i] = a_roll[i*`COPAD_ROLL_W +: `COPAD_ROLL_W];
        assign b_roll_arr[i] = b_roll[i*`COPAD_ROLL_W +: `COPAD_ROLL_W];
        assign a_pad_arr[i]  = a_pad[i*`COPAD_PAD_W +: `COPAD_PAD_W];
        assign b_pad_arr[i]  = b_pad[i*`COPAD_PAD_W +: `COPAD_PAD_W];
        assign a_cnt_arr[i]  = a_cnt[i*`COPAD_CNT_W +: `COPAD_CNT_W];
        assign b_cnt_arr[i]  = b_cnt[i*`COPAD_CNT_W +: `COPAD_CNT_W];
    end

    copad_window_if win ();   // stage 1 to stage 2

    // --------------------
    // pipeline stages
    cluster_window i_cluster_window (
        .clock              (clock),
        .rst                (rst),
        .match_neighbor_pad (match_neighbor_pad),
        .match_delta_pad    (match_delta_pad),
        .a_vpf              (a_vpf),
        .b_vpf              (b_vpf),
        .a_roll             (a_roll_arr),
        .b_roll             (b_roll_arr),
        .a_pad              (a_pad_arr),
        .b_pad              (b_pad_arr),
        .a_cnt              (a_cnt_arr),
        .b_cnt              (b_cnt_arr),
        .win                (win.producer)
    );

    pair_match i_pair_match (
        .clock               (clock),
        .rst                 (rst),
        .match_neighbor_roll (match_neighbor_roll),
        .win                 (win.consumer),
        .match               (match),
        .match_upper         (match_upper),
        .match_lower         (match_lower),
        .any_match           (any_match)
    );

endmodule

// File: src/pair_match.sv
// stage 2; neighbor-roll enable is sampled here, rolls at the chamber ends never wrap
`include "copad_config.svh"

module pair_match
    import copad_pkg::*;
(
    input  logic  clock,
    input  logic  rst,
    input  logic  match_neighbor_roll,
    copad_window_if.consumer win,
    output mask_t match,
    output mask_t match_upper,
    output mask_t match_lower,
    output logic  any_match
);

    localparam int N = `COPAD_N_CLUSTERS;

    // row i is one A cluster, bit j one B cluster
    mask_t pad_hit [N];
    mask_t pair_c  [N];   // same roll
    mask_t pair_u  [N];   // A roll is B roll plus one
    mask_t pair_l  [N];   // B roll is A roll plus one

    logic [`COPAD_ROLL_W:0] a_rx [N];   // rolls with a carry bit
    logic [`COPAD_ROLL_W:0] b_rx [N];

    mask_t match_center;
    mask_t upper_hit;
    mask_t lower_hit;
    mask_t match_full;

    // --------------------
    // all 64 A-B pairs
    always_comb begin
        for (int i = 0; i < N; i++) begin
            a_rx[i] = {1'b0, win.a_roll[i]};
            b_rx[i] = {1'b0, win.b_roll[i]};
        end
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                // either end of the B cluster inside the A window
                pad_hit[i][j] = (win.b_lo[j] >= win.a_min[i] && win.b_lo[j] <= win.a_max[i])
                             || (win.b_hi[j] >= win.a_min[i] && win.b_hi[j] <= win.a_max[i]);
                pad_hit[i][j] = pad_hit[i][j] && win.a_vld[i] && win.b_vld[j];

                pair_c[i][j] = pad_hit[i][j] && (a_rx[i] == b_rx[j]);
                pair_u[i][j] = pad_hit[i][j] && (a_rx[i] == b_rx[j] + 1'b1);
                pair_l[i][j] = pad_hit[i][j] && (b_rx[j] == a_rx[i] + 1'b1);
            end
        end
    end

    // --------------------
    // row reduction
    for (genvar i = 0; i < N; i++) begin : g_row
        assign match_center[i] = |pair_c[i];
        assign upper_hit[i]    = |pair_u[i];
        assign lower_hit[i]    = |pair_l[i];
    end

    // neighbor rolls count only when enabled
    assign match_full = match_center
                      | ({N{match_neighbor_roll}} & (upper_hit | lower_hit));

    // --------------------
    // output registers
    always_ff @(posedge clock) begin
        if (rst) begin
            match       <= '0;
            match_upper <= '0;
            match_lower <= '0;
            any_match   <= 1'b0;
        end else begin
            match       <= match_full;
            match_upper <= upper_hit;    // reported regardless of the enable
            match_lower <= lower_hit;
            any_match   <= |match_full;
        end
    end

endmodule

// File: src/cluster_window.sv
// stage 1; delta and neighbor-pad enable are sampled here, window math assumes pads 0..191
`include "copad_config.svh"

module cluster_window
    import copad_pkg::*;
(
    input  logic   clock,
    input  logic   rst,
    input  logic   match_neighbor_pad,
    input  delta_t match_delta_pad,
    input  mask_t  a_vpf,
    input  mask_t  b_vpf,
    input  roll_t  a_roll [`COPAD_N_CLUSTERS],
    input  roll_t  b_roll [`COPAD_N_CLUSTERS],
    input  pad_t   a_pad  [`COPAD_N_CLUSTERS],
    input  pad_t   b_pad  [`COPAD_N_CLUSTERS],
    input  cnt_t   a_cnt  [`COPAD_N_CLUSTERS],
    input  cnt_t   b_cnt  [`COPAD_N_CLUSTERS],
    copad_window_if.producer win
);

    delta_t delta_eff;
    xpad_t  delta_x;
    xpad_t  a_sum [`COPAD_N_CLUSTERS];   // unclamped high end of A window
    xpad_t  a_min_d [`COPAD_N_CLUSTERS];
    xpad_t  a_max_d [`COPAD_N_CLUSTERS];
    xpad_t  b_hi_d  [`COPAD_N_CLUSTERS];

    // tolerance only applies when neighbor-pad matching is on
    assign delta_eff = match_neighbor_pad ? match_delta_pad : '0;
    assign delta_x   = xpad_t'(delta_eff);

    // --------------------
    // per-cluster window and span
    for (genvar i = 0; i < `COPAD_N_CLUSTERS; i++) begin : g_win
        assign a_sum[i] = xpad_t'(a_pad[i]) + xpad_t'(a_cnt[i]) + delta_x;

        // low edge clamps to pad 0
        assign a_min_d[i] = (xpad_t'(a_pad[i]) < delta_x) ? '0
                                                          : xpad_t'(a_pad[i]) - delta_x;

        // high edge clamps to the last pad
        assign a_max_d[i] = (a_sum[i] > xpad_t'(`COPAD_MAX_PAD)) ? xpad_t'(`COPAD_MAX_PAD)
                                                                  : a_sum[i];

        assign b_hi_d[i] = xpad_t'(b_pad[i]) + xpad_t'(b_cnt[i]);   // far end of B cluster
    end

    // --------------------
    // stage 1 registers
    always_ff @(posedge clock) begin
        if (rst) begin
            win.a_vld <= '0;
            win.b_vld <= '0;
        end else begin
            win.a_vld <= a_vpf;
            win.b_vld <= b_vpf;
        end
    end

    // window and span payload
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `COPAD_N_CLUSTERS; i++) begin
                win.a_roll[i] <= '0;
                win.a_min[i]  <= '0;
                win.a_max[i]  <= '0;
                win.b_roll[i] <= '0;
                win.b_lo[i]   <= '0;
                win.b_hi[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < `COPAD_N_CLUSTERS; i++) begin
                win.a_roll[i] <= a_roll[i];
                win.a_min[i]  <= a_min_d[i];
                win.a_max[i]  <= a_max_d[i];
                win.b_roll[i] <= b_roll[i];
                win.b_lo[i]   <= xpad_t'(b_pad[i]);
                win.b_hi[i]   <= b_hi_d[i];
            end
        end
    end

endmodule

// File: src/copad_window_if.sv
// carries one crossing per clock from stage 1 to stage 2; no handshake, no stall
`include "copad_config.svh"

interface copad_window_if
    import copad_pkg::*;
();

    // --------------------
    // chamber A windows
    mask_t a_vld;                          // valid flag per cluster
    roll_t a_roll [`COPAD_N_CLUSTERS];
    xpad_t a_min  [`COPAD_N_CLUSTERS];     // low bound, clamped at 0
    xpad_t a_max  [`COPAD_N_CLUSTERS];     // high bound, clamped at max pad

    // --------------------
    // chamber B spans
    mask_t b_vld;
    roll_t b_roll [`COPAD_N_CLUSTERS];
    xpad_t b_lo   [`COPAD_N_CLUSTERS];     // start pad
    xpad_t b_hi   [`COPAD_N_CLUSTERS];     // start pad plus count, not clamped

    // stage 1 side
    modport producer (output a_vld, a_roll, a_min, a_max,
                      output b_vld, b_roll, b_lo, b_hi);

    // stage 2 side
    modport consumer (input a_vld, a_roll, a_min, a_max,
                      input b_vld, b_roll, b_lo, b_hi);

endinterface

// File: src/copad_pkg.sv
// width types only; every width is set by the macros in copad_config.svh
`include "copad_config.svh"

package copad_pkg;

    // --------------------
    // cluster fields
    typedef logic [`COPAD_PAD_W-1:0]   pad_t;
    typedef logic [`COPAD_ROLL_W-1:0]  roll_t;
    typedef logic [`COPAD_CNT_W-1:0]   cnt_t;   // extra pads, 0..7

    // configured tolerance
    typedef logic [`COPAD_DELTA_W-1:0] delta_t;

    // --------------------
    // derived values
    typedef logic [`COPAD_XPAD_W-1:0]  xpad_t;  // pad plus carry bit

    // one bit per chamber A cluster
    typedef logic [`COPAD_N_CLUSTERS-1:0] mask_t;

endpackage

// File: src/copad_config.svh
// fixed detector geometry (8 rolls of 192 pads, 8 clusters per chamber); not meant to be retuned
`ifndef COPAD_CONFIG_SVH
`define COPAD_CONFIG_SVH

// --------------------
// cluster geometry
`define COPAD_N_CLUSTERS 8     // clusters per chamber per crossing
`define COPAD_MAX_PAD    191   // last pad in a roll
`define COPAD_LAST_ROLL  7     // last roll number

// --------------------
// field widths
`define COPAD_PAD_W      8
`define COPAD_ROLL_W     3
`define COPAD_CNT_W      3     // extra pads beyond the start pad
`define COPAD_DELTA_W    4     // configured pad tolerance, 0 to 15

// pad sums carry one extra bit so values past 191 stay visible
`define COPAD_XPAD_W     (`COPAD_PAD_W + 1)

`endif
